/* Bender.yml */
package:
  name: mz_top

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mz_pkg.sv
      - hdl/mz_if.sv
      - hdl/mz_bus_slave.sv
      - hdl/mz_reg_file.sv
      - hdl/mz_sample_buf.sv
      - hdl/mz_decode_engine.sv
      - hdl/mz_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/mz_checker.sv
      - sim/tb_mz_top.sv

/* hdl/mz_bus_slave.sv */
`include "mz_consts.svh"

module mz_bus_slave (
  input  logic                 FPGA_CLK3,
  input  logic                 SYS_RST_N,
  input  mz_pkg::host_addr_t   mz_addr,
  input  mz_pkg::host_data_t   mz_data_in,
  output mz_pkg::host_data_t   mz_data_out,
  output logic                 mz_data_oe,
  input  logic                 mz_as,
  input  logic                 mz_rw,
  input  logic [`MZ_LANES-1:0] mz_byte_n,
  output logic                 mz_dtack,
  mz_wb_if.master              wb
);
  import mz_pkg::*;

  bus_state_e           state;
  logic [1:0]           as_sync;      // Strobe synchronizer
  logic                 as_detected;
  logic                 cyc_q;        // Wishbone cycle request
  host_addr_t           addr_q;
  host_data_t           wdata_q;
  host_data_t           rdata_q;
  logic                 rw_q;
  logic [`MZ_LANES-1:0] byte_n_q;

  // ----------------------------------------------------------------------
  // Strobe synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      as_sync <= '0;
    end else begin
      as_sync <= {as_sync[0], mz_as};   // Shift in raw pin
    end
  end

  // Both flops high, dropped at once with the raw pin
  assign as_detected = as_sync[1] & as_sync[0] & mz_as;

  // ----------------------------------------------------------------------
  // Access state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      state    <= BUS_IDLE;
      cyc_q    <= 1'b0;
      mz_dtack <= 1'b0;
    end else begin
      case (state)
        BUS_IDLE: if (as_detected) begin
          cyc_q <= 1'b1;                  // Open Wishbone cycle
          state <= BUS_ACCESS;
        end
        BUS_ACCESS: if (wb.ack) begin
          cyc_q <= 1'b0;                  // One transfer per access
          state <= BUS_ACK;
        end
        BUS_ACK: begin
          mz_dtack <= 1'b1;               // Data already latched
          state    <= BUS_HOLD;
        end
        BUS_HOLD: if (!as_detected) begin
          mz_dtack <= 1'b0;               // Host released strobe
          state    <= BUS_IDLE;
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // Bus payload, captured at strobe and at ack
  always_ff @(posedge FPGA_CLK3) begin
    if (state == BUS_IDLE && as_detected) begin
      addr_q   <= mz_addr;
      wdata_q  <= mz_data_in;
      rw_q     <= mz_rw;
      byte_n_q <= mz_byte_n;
    end
    if (state == BUS_ACCESS && wb.ack) begin
      rdata_q <= wb.dat_r;
    end
  end

  assign wb.cyc      = cyc_q;
  assign wb.stb      = cyc_q;
  assign wb.we       = ~rw_q;         // rw high is a read
  assign wb.adr      = addr_q;
  assign wb.dat_w    = wdata_q;
  assign wb.sel      = ~byte_n_q;     // Active-low byte strobes
  assign mz_data_out = rdata_q;
  assign mz_data_oe  = mz_rw & mz_as; // Drive bus only during a read

endmodule

/* hdl/mz_consts.svh */
`ifndef MZ_CONSTS_SVH
`define MZ_CONSTS_SVH

// ----------------------------------------------------------------------
// Host bus geometry
// ----------------------------------------------------------------------
`define MZ_ADDR_W      24       // Host byte address
`define MZ_DATA_W      32       // Bus word
`define MZ_SAMPLE_W    8        // One distance sample
`define MZ_LANES       4        // Samples packed per bus word

// ----------------------------------------------------------------------
// Sample buffers and register map
// ----------------------------------------------------------------------
`define MZ_BUF_AW      10       // 1024 entries per buffer

`define MZ_REG_RUN     'h00     // Run trigger, held until decode done
`define MZ_REG_STATUS  'h04     // Bit 0 ready, bit 1 sticky done
`define MZ_REG_N1      'h18     // Block length in samples

// Region field sits above the 4 KB window offset
`define MZ_REGION_LSB  12

`endif

/* hdl/mz_decode_engine.sv */
module mz_decode_engine (
  input  logic              FPGA_CLK3,
  input  logic              SYS_RST_N,
  input  logic              start,
  input  mz_pkg::buf_addr_t n1,
  output logic              ready,
  output logic              done,
  output logic              owns,
  mz_mem_if.requester       dist0,
  mz_mem_if.requester       dist1,
  mz_mem_if.requester       bits
);
  import mz_pkg::*;

  eng_state_e state;
  buf_addr_t  idx;          // Current sample index
  buf_addr_t  idx_nxt;
  buf_addr_t  n1_q;         // Block length for this run
  logic       decision;

  assign idx_nxt  = idx + 1'b1;
  assign ready    = (state == ENG_IDLE);
  assign owns     = (state != ENG_IDLE);                // Buffers held for whole run
  assign decision = (dist1.rdata < dist0.rdata);        // Hard decision, ties give 0

  // Distance reads in ENG_READ, decision write in ENG_WRITE
  assign dist0.addr  = idx;
  assign dist0.en    = (state == ENG_READ);
  assign dist0.we    = 1'b0;
  assign dist0.wdata = '0;
  assign dist1.addr  = idx;
  assign dist1.en    = (state == ENG_READ);
  assign dist1.we    = 1'b0;
  assign dist1.wdata = '0;
  assign bits.addr   = idx;
  assign bits.en     = (state == ENG_WRITE);
  assign bits.we     = (state == ENG_WRITE);
  assign bits.wdata  = decision;

  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      state <= ENG_IDLE;
      done  <= 1'b0;
      idx   <= '0;
      n1_q  <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        ENG_IDLE: if (start) begin
          idx   <= '0;
          n1_q  <= n1;
          state <= (n1 == '0) ? ENG_DONE : ENG_READ;    // Empty block skips the walk
        end
        ENG_READ:  state <= ENG_WRITE;                  // rdata lands next cycle
        ENG_WRITE: begin
          idx   <= idx_nxt;
          state <= (idx_nxt == n1_q) ? ENG_DONE : ENG_READ;
        end
        ENG_DONE: begin
          done  <= 1'b1;                                // Single pulse, owns drops too
          state <= ENG_IDLE;
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

/* hdl/mz_if.sv */
`include "mz_consts.svh"

// Wishbone classic, bus front end to register block
interface mz_wb_if;
  import mz_pkg::*;

  logic                 cyc;    // Cycle in progress
  logic                 stb;    // Strobe, tied to cyc here
  logic                 we;     // 1 = write
  host_addr_t           adr;    // Byte address
  host_data_t           dat_w;  // Write data
  host_data_t           dat_r;  // Read data
  logic [`MZ_LANES-1:0] sel;    // Byte lane enables
  logic                 ack;    // One-cycle acknowledge

  modport master (output cyc, stb, we, adr, dat_w, sel, input dat_r, ack);
  modport slave  (input cyc, stb, we, adr, dat_w, sel, output dat_r, ack);

endinterface

// Single memory port, rdata one cycle after en
interface mz_mem_if #(
  parameter int WIDTH = 8
);
  import mz_pkg::*;

  buf_addr_t        addr;
  logic             en;
  logic             we;
  logic [WIDTH-1:0] wdata;
  logic [WIDTH-1:0] rdata;

  modport requester (output addr, en, we, wdata, input rdata);
  modport ram       (input addr, en, we, wdata, output rdata);

endinterface

/* hdl/mz_pkg.sv */
`include "mz_consts.svh"

package mz_pkg;

  typedef logic [`MZ_ADDR_W-1:0]   host_addr_t;   // Host byte address
  typedef logic [`MZ_DATA_W-1:0]   host_data_t;   // Bus word
  typedef logic [`MZ_SAMPLE_W-1:0] sample_t;      // Distance sample
  typedef logic [`MZ_BUF_AW-1:0]   buf_addr_t;    // Buffer index

  // Address window select
  typedef enum logic [3:0] {
    REGION_CTRL  = 4'd0,    // Control registers
    REGION_DIST0 = 4'd1,    // rTow0 distances
    REGION_DIST1 = 4'd2,    // rTow1 distances
    REGION_BITS  = 4'd3     // Decision bits, one per word
  } region_e;

  typedef enum logic [1:0] {BUS_IDLE, BUS_ACCESS, BUS_ACK, BUS_HOLD} bus_state_e;

  typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_WRITE, ENG_DONE} eng_state_e;

endpackage

/* hdl/mz_reg_file.sv */
`include "mz_consts.svh"

module mz_reg_file (
  input  logic              FPGA_CLK3,
  input  logic              SYS_RST_N,
  mz_wb_if.slave            wb,
  mz_mem_if.requester       dist0,
  mz_mem_if.requester       dist1,
  mz_mem_if.requester       bits,
  output logic              start,
  output mz_pkg::buf_addr_t n1,
  input  logic              ready,
  input  logic              done
);
  import mz_pkg::*;

  localparam int LANE_W = $clog2(`MZ_LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`MZ_LANES - 1);

  region_e                   region;
  logic [`MZ_REGION_LSB-1:0] offset;       // Offset inside control window
  logic                      access;       // Request not yet acked
  logic                      ack_q;
  logic [LANE_W-1:0]         lane;         // Sample lane being written
  logic                      buf_wr;
  logic                      run_q;
  logic                      run_wait;     // Run write parked until done
  logic                      done_seen;    // Sticky done
  host_data_t                rd_data;

  assign region = region_e'(wb.adr[`MZ_REGION_LSB +: $bits(region_e)]);
  assign offset = wb.adr[`MZ_REGION_LSB-1:0];
  assign access = wb.cyc & wb.stb & ~ack_q;
  assign buf_wr = access & wb.we & wb.sel[lane];  // Masked lanes still use a cycle

  // ----------------------------------------------------------------------
  // Lane unpacker and buffer ports
  // ----------------------------------------------------------------------
  assign dist0.addr  = {wb.adr[`MZ_BUF_AW-1:LANE_W], lane};
  assign dist0.wdata = wb.dat_w[lane*`MZ_SAMPLE_W +: `MZ_SAMPLE_W];
  assign dist0.en    = buf_wr & (region == REGION_DIST0);
  assign dist0.we    = buf_wr & (region == REGION_DIST0);
  assign dist1.addr  = {wb.adr[`MZ_BUF_AW-1:LANE_W], lane};
  assign dist1.wdata = wb.dat_w[lane*`MZ_SAMPLE_W +: `MZ_SAMPLE_W];
  assign dist1.en    = buf_wr & (region == REGION_DIST1);
  assign dist1.we    = buf_wr & (region == REGION_DIST1);
  assign bits.addr   = wb.adr[`MZ_BUF_AW+1:2];    // One bit per word
  assign bits.en     = wb.cyc & wb.stb & ~wb.we & (region == REGION_BITS);
  assign bits.we     = 1'b0;
  assign bits.wdata  = '0;

  // Readback mux
  always_comb begin
    rd_data = '0;
    case (region)
      REGION_CTRL: case (offset)
        `MZ_REG_RUN:    rd_data[0]              = run_q;
        `MZ_REG_STATUS: rd_data[1:0]            = {done_seen, ready};
        `MZ_REG_N1:     rd_data[`MZ_BUF_AW-1:0] = n1;
        default: ;
      endcase
      REGION_BITS: rd_data[0] = bits.rdata;    // RAM output, valid with ack
      default: ;
    endcase
  end

  assign wb.dat_r = rd_data;
  assign wb.ack   = ack_q;

  // ----------------------------------------------------------------------
  // Control registers and acknowledge
  // ----------------------------------------------------------------------
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      ack_q     <= 1'b0;
      start     <= 1'b0;
      lane      <= '0;
      run_q     <= 1'b0;
      run_wait  <= 1'b0;
      done_seen <= 1'b0;
      n1        <= '0;
    end else begin
      ack_q <= 1'b0;
      start <= 1'b0;
      if (done) done_seen <= 1'b1;
      if (run_wait) begin
        if (done) begin
          ack_q    <= 1'b1;       // Release the run transaction
          run_wait <= 1'b0;
          run_q    <= 1'b0;
        end
      end else if (access) begin
        case (region)
          REGION_CTRL: begin
            if (wb.we && offset == `MZ_REG_RUN) begin
              run_q     <= wb.dat_w[0];
              done_seen <= 1'b0;                  // New run clears done
              start     <= wb.dat_w[0];
              run_wait  <= wb.dat_w[0];
              ack_q     <= ~wb.dat_w[0];          // Writing 0 acks at once
            end else begin
              if (wb.we && offset == `MZ_REG_N1) n1 <= wb.dat_w[`MZ_BUF_AW-1:0];
              ack_q <= 1'b1;
            end
          end
          REGION_DIST0, REGION_DIST1: begin
            if (wb.we) begin
              lane  <= lane + 1'b1;               // Wraps to 0 after last lane
              ack_q <= (lane == LAST_LANE);
            end else begin
              ack_q <= 1'b1;                      // No distance readback
            end
          end
          default: ack_q <= 1'b1;
        endcase
      end
    end
  end

endmodule

/* hdl/mz_sample_buf.sv */
`include "mz_consts.svh"

module mz_sample_buf #(
  parameter int WIDTH = 8
) (
  input  logic  FPGA_CLK3,
  mz_mem_if.ram host,
  mz_mem_if.ram eng,
  input  logic  owns
);
  import mz_pkg::*;

  logic [WIDTH-1:0] mem [2**`MZ_BUF_AW];
  logic [WIDTH-1:0] rdata_q;
  logic [WIDTH-1:0] wdata;
  buf_addr_t        addr;
  logic             en;
  logic             we;

  // Ownership mux, engine wins while decoding
  assign addr  = owns ? eng.addr  : host.addr;
  assign en    = owns ? eng.en    : host.en;
  assign we    = owns ? eng.we    : host.we;
  assign wdata = owns ? eng.wdata : host.wdata;

  always_ff @(posedge FPGA_CLK3) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      rdata_q <= mem[addr];       // Read-first, one cycle latency
    end
  end

  assign host.rdata = rdata_q;    // Shared by both sides
  assign eng.rdata  = rdata_q;

endmodule

/* hdl/mz_top.sv */
`include "mz_consts.svh"

module mz_top (
  input  logic                 FPGA_CLK3,
  input  logic                 SYS_RST_N,
  input  mz_pkg::host_addr_t   mz_addr,
  input  mz_pkg::host_data_t   mz_data_in,
  output mz_pkg::host_data_t   mz_data_out,
  output logic                 mz_data_oe,
  input  logic                 mz_as,
  input  logic                 mz_rw,
  input  logic [`MZ_LANES-1:0] mz_byte_n,
  output logic                 mz_dtack
);
  import mz_pkg::*;

  logic      start;       // Run trigger to engine
  logic      ready;
  logic      done;
  logic      owns;        // Engine holds all three buffers
  buf_addr_t n1;

  // ----------------------------------------------------------------------
  // Internal buses
  // ----------------------------------------------------------------------
  mz_wb_if wb ();

  mz_mem_if #(.WIDTH(`MZ_SAMPLE_W)) dist0_host ();
  mz_mem_if #(.WIDTH(`MZ_SAMPLE_W)) dist0_eng ();
  mz_mem_if #(.WIDTH(`MZ_SAMPLE_W)) dist1_host ();
  mz_mem_if #(.WIDTH(`MZ_SAMPLE_W)) dist1_eng ();
  mz_mem_if #(.WIDTH(1))            bits_host ();
  mz_mem_if #(.WIDTH(1))            bits_eng ();

  mz_bus_slave u_bus_slave (
    .FPGA_CLK3, .SYS_RST_N, .mz_addr, .mz_data_in, .mz_data_out, .mz_data_oe,
    .mz_as, .mz_rw, .mz_byte_n, .mz_dtack, .wb(wb)
  );

  mz_reg_file u_reg_file (
    .FPGA_CLK3, .SYS_RST_N, .wb(wb), .dist0(dist0_host), .dist1(dist1_host),
    .bits(bits_host), .start, .n1, .ready, .done
  );

  mz_decode_engine u_decode_engine (
    .FPGA_CLK3, .SYS_RST_N, .start, .n1, .ready, .done, .owns,
    .dist0(dist0_eng), .dist1(dist1_eng), .bits(bits_eng)
  );

  mz_sample_buf #(.WIDTH(`MZ_SAMPLE_W)) dist0_buf (
    .FPGA_CLK3, .host(dist0_host), .eng(dist0_eng), .owns
  );
  mz_sample_buf #(.WIDTH(`MZ_SAMPLE_W)) dist1_buf (
    .FPGA_CLK3, .host(dist1_host), .eng(dist1_eng), .owns
  );
  mz_sample_buf #(.WIDTH(1)) bits_buf (
    .FPGA_CLK3, .host(bits_host), .eng(bits_eng), .owns
  );

endmodule

/* project.f */
+incdir+hdl
hdl/mz_pkg.sv
hdl/mz_if.sv
hdl/mz_bus_slave.sv
hdl/mz_reg_file.sv
hdl/mz_sample_buf.sv
hdl/mz_decode_engine.sv
hdl/mz_top.sv
sim/mz_checker.sv
sim/tb_mz_top.sv

/* sim/mz_checker.sv */
module mz_checker (
  input logic FPGA_CLK3,
  input logic SYS_RST_N,
  input logic mz_as,
  input logic mz_rw,
  input logic mz_dtack,
  input logic mz_data_oe
);

  int fail_count = 0;   // Assertion failures seen so far

  // ----------------------------------------------------------------------
  // Host handshake rules
  // ----------------------------------------------------------------------
  dtack_in_reset: assert property (@(posedge FPGA_CLK3) !SYS_RST_N |-> !mz_dtack)
    else begin
      fail_count++;
      $error("mz_dtack high while reset is active");
    end

  dtack_needs_as: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    $rose(mz_dtack) |-> mz_as)                          // No acknowledge without strobe
    else begin
      fail_count++;
      $error("mz_dtack rose while mz_as was low");
    end

  dtack_release: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    $fell(mz_as) |-> ##[0:3] !mz_dtack)                 // Falls within 3 cycles
    else begin
      fail_count++;
      $error("mz_dtack still high 3 cycles after mz_as fell");
    end

  oe_follows_read: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    mz_data_oe == (mz_rw && mz_as))
    else begin
      fail_count++;
      $error("mz_data_oe differs from mz_rw and mz_as");
    end

endmodule

bind mz_top mz_checker u_checker (
  .FPGA_CLK3, .SYS_RST_N, .mz_as, .mz_rw, .mz_dtack, .mz_data_oe
);

/* sim/tb_mz_top.sv */
`include "mz_consts.svh"

module tb_mz_top;
  import mz_pkg::*;

  localparam int HALF_PERIOD   = 50;
  localparam int DTACK_LIMIT   = 2000;  // Long enough for a full run
  localparam int RELEASE_LIMIT = 3;     // Cycles for dtack to drop

  logic                 FPGA_CLK3;
  logic                 SYS_RST_N;
  host_addr_t           mz_addr;
  host_data_t           mz_data_in;
  host_data_t           mz_data_out;
  logic                 mz_data_oe;
  logic                 mz_as;
  logic                 mz_rw;
  logic [`MZ_LANES-1:0] mz_byte_n;
  logic                 mz_dtack;

  integer  seed;
  int      checks = 0;
  int      errors = 0;
  sample_t d0_model [2**`MZ_BUF_AW];    // Host view of rTow0
  sample_t d1_model [2**`MZ_BUF_AW];    // Host view of rTow1

  mz_top dut (
    .FPGA_CLK3, .SYS_RST_N, .mz_addr, .mz_data_in, .mz_data_out, .mz_data_oe,
    .mz_as, .mz_rw, .mz_byte_n, .mz_dtack
  );

  initial begin
    FPGA_CLK3 = 1'b0;
    forever #HALF_PERIOD FPGA_CLK3 = ~FPGA_CLK3;
  end

  // ----------------------------------------------------------------------
  // Host bus helpers
  // ----------------------------------------------------------------------
  function automatic host_addr_t make_addr(input region_e region, input logic [11:0] offset);
    return {8'h00, region, offset};     // Region above the 4 KB window
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic start_access(input host_addr_t addr, input host_data_t data,
                              input logic rw, input logic [3:0] byte_n);
    @(posedge FPGA_CLK3);
    check("mz_dtack before mz_as", 32'(mz_dtack), 32'h0);  // Idle bus
    mz_addr    <= addr;
    mz_data_in <= data;
    mz_rw      <= rw;
    mz_byte_n  <= byte_n;
    mz_as      <= 1'b1;
  endtask

  task automatic wait_dtack(input host_addr_t addr);
    int n;
    n = 0;
    do begin
      @(posedge FPGA_CLK3);
      n++;
    end while (!mz_dtack && n < DTACK_LIMIT);
    if (!mz_dtack) begin
      errors++;
      $display("No dtack for address 0x%0h after %0d cycles", addr, DTACK_LIMIT);
    end
  endtask

  task automatic end_access;
    int n;
    n = 0;
    mz_as <= 1'b0;                      // Same edge that saw dtack
    do begin
      @(posedge FPGA_CLK3);
      n++;
    end while (mz_dtack && n < RELEASE_LIMIT);
    if (mz_dtack) begin
      errors++;
      $display("dtack did not fall within %0d cycles of as falling", RELEASE_LIMIT);
    end
  endtask

  task automatic bus_write(input host_addr_t addr, input host_data_t data,
                           input logic [3:0] byte_n);
    start_access(addr, data, 1'b0, byte_n);
    wait_dtack(addr);
    check("mz_data_oe", 32'(mz_data_oe), 32'h0);   // Write leaves the bus to the host
    end_access();
  endtask

  task automatic bus_read(input host_addr_t addr, output host_data_t data);
    start_access(addr, '0, 1'b1, 4'h0);
    wait_dtack(addr);
    check("mz_data_oe", 32'(mz_data_oe), 32'h1);   // Read drives the bus
    data = mz_data_out;                 // Valid while dtack high
    end_access();
  endtask

  task automatic read_check(input host_addr_t addr, input host_data_t exp, input string name);
    host_data_t got;
    bus_read(addr, got);
    check(name, got, exp);
  endtask

  // Buffer word write that updates only the enabled lanes in the model
  task automatic write_dist(input region_e region, input int word, input host_data_t data,
                            input logic [3:0] byte_n);
    int k;
    bus_write(make_addr(region, 12'(word * 4)), data, byte_n);
    for (k = 0; k < `MZ_LANES; k++) begin
      if (!byte_n[k] && region == REGION_DIST0) d0_model[word*4+k] = data[8*k +: 8];
      if (!byte_n[k] && region == REGION_DIST1) d1_model[word*4+k] = data[8*k +: 8];
    end
  endtask

  task automatic run_and_check(input int n1);
    host_data_t got;
    int i;
    bus_write(make_addr(REGION_CTRL, `MZ_REG_RUN), 32'h1, 4'h0);    // Blocks until done
    read_check(make_addr(REGION_CTRL, `MZ_REG_STATUS), 32'h3, "status");
    for (i = 0; i < n1; i++) begin
      bus_read(make_addr(REGION_BITS, 12'(i * 4)), got);
      check($sformatf("mz_data_out bit %0d", i), got, {31'd0, d1_model[i] < d0_model[i]});
    end
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state;
    @(posedge FPGA_CLK3);
    check("mz_dtack after reset", 32'(mz_dtack), 32'h0);
    read_check(make_addr(REGION_CTRL, `MZ_REG_STATUS), 32'h1, "status");  // Ready set, done clear
  endtask

  task automatic test_registers;
    logic [11:0] off;
    bus_write(make_addr(REGION_CTRL, `MZ_REG_N1), 32'h2a5, 4'h0);
    read_check(make_addr(REGION_CTRL, `MZ_REG_N1), 32'h2a5, "n1");
    read_check(make_addr(REGION_CTRL, `MZ_REG_RUN), 32'h0, "run");
    for (off = 12'h008; off <= 12'h01c; off += 12'h004) begin
      if (off != `MZ_REG_N1) read_check(make_addr(REGION_CTRL, off), 32'h0, "unused reg");
    end
  endtask

  task automatic test_decode;
    int w;
    bus_write(make_addr(REGION_CTRL, `MZ_REG_N1), 32'd64, 4'h0);
    for (w = 0; w < 16; w++) begin
      write_dist(REGION_DIST0, w, $random(seed), 4'h0);
      write_dist(REGION_DIST1, w, (w == 5) ?                       // Word 5 all ties
                 {d0_model[23], d0_model[22], d0_model[21], d0_model[20]} :
                 $random(seed), 4'h0);
    end
    run_and_check(64);
  endtask

  task automatic test_lane_mask;
    write_dist(REGION_DIST0, 2, $random(seed), 4'b0101);
    write_dist(REGION_DIST1, 7, $random(seed), 4'b1000);
    write_dist(REGION_DIST0, 11, $random(seed), 4'b0110);
    write_dist(REGION_DIST1, 15, $random(seed), 4'b1111);  // Nothing lands
    run_and_check(64);
  endtask

  task automatic test_handshake;
    int n;
    start_access(make_addr(REGION_CTRL, `MZ_REG_STATUS), '0, 1'b1, 4'h0);
    wait_dtack(make_addr(REGION_CTRL, `MZ_REG_STATUS));
    for (n = 0; n < 4; n++) begin       // Host stalls with as still up
      @(posedge FPGA_CLK3);
      check("mz_dtack while mz_as high", 32'(mz_dtack), 32'h1);
    end
    check("status", mz_data_out, 32'h3);
    end_access();
    read_check(make_addr(REGION_CTRL, `MZ_REG_N1), 32'd64, "n1");  // Next access
  endtask

  initial begin
    seed       = 49406;
    SYS_RST_N  <= 1'b0;
    mz_addr    <= '0;
    mz_data_in <= '0;
    mz_as      <= 1'b0;
    mz_rw      <= 1'b0;
    mz_byte_n  <= '0;
    repeat (4) @(posedge FPGA_CLK3);
    SYS_RST_N <= 1'b1;

    test_reset_state();
    test_registers();
    test_decode();
    test_lane_mask();
    test_handshake();

    $display("Checks run: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut.u_checker.fail_count);
    if (errors == 0 && dut.u_checker.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
